//--- bench/tbChecker.sv
`timescale 1ns/1ns
`include "risc621_defines.svh"

module tbChecker import risc621Pkg::*; (
	input  logic       Clock_pin,
	input  logic       rstN,
	input  logic       run,
	input  logic       dmWrite,
	input  wordT       dmAddr,
	input  wordT       dmWrData,
	input  wordT       pcOut,
	input  int         testNum,
	input  logic [2:0] kind,
	input  opcodeE     op,
	input  wordT       a,
	input  wordT       b,
	input  logic       carry,
	input  logic [3:0] cond,
	input  logic       testDone,
	input  logic       allDone,
	output int         failCount
);

	localparam logic [2:0] kindIdle = 3'd0;
	localparam logic [2:0] kindAlu = 3'd1;
	localparam logic [2:0] kindJump = 3'd2;
	localparam logic [2:0] kindLoad = 3'd3;

	int   storeCount = 0;
	int   passCount = 0;
	int   runCount = 0;
	logic haltErr = 1'b0;
	logic summaryDone = 1'b0;
	wordT gotAddr;
	wordT gotData;

	initial failCount = 0;

	function automatic int toSigned(input wordT w);
		return w[`WORD_W-1] ? int'(w) - 16384 : int'(w);
	endfunction

	// ------------------------------
	// reference model returning {c n v z, result}
	// ------------------------------

	function automatic logic [17:0] model(input opcodeE o, input wordT x, input wordT y,
		input logic cin);
		logic c;
		logic n;
		logic v;
		logic z;
		wordT r;
		wordT yy;
		int   s;
		int   k;
		c = cin;  // flags left by the preset ADD
		z = cin;
		n = 1'b0;
		v = 1'b0;
		r = x;
		yy = (o == ADDC || o == SUBC) ? {10'b0, y[3:0]} : y;
		k = int'(y[3:0]);
		case (o)
			ADD, ADDC: begin
				s = int'(x) + int'(yy);
				r = wordT'(s);
				c = (s > 16383);
				s = toSigned(x) + toSigned(yy);
				v = (s > 8191) || (s < -8192);
			end
			SUB, SUBC: begin
				r = x - yy;
				c = (x >= yy);  // no borrow
				s = toSigned(x) - toSigned(yy);
				v = (s > 8191) || (s < -8192);
			end
			NOT: r = ~x;
			AND: r = x & y;
			OR: r = x | y;
			XOR: r = x ^ y;
			CPY: r = y;
			SHLL, SHLA: repeat (k) r = r << 1;
			SHRL: repeat (k) r = r >> 1;
			SHRA: repeat (k) r = {r[13], r[13:1]};
			ROTL: repeat (k % 14) r = {r[12:0], r[13]};
			ROTR: repeat (k % 14) r = {r[0], r[13:1]};
			RTLC: repeat (k) {r, c} = {r[12:0], c, r[13]};
			RTRC: repeat (k) {r, c} = {c, r[13:1], r[0]};
			default: r = x;
		endcase
		case (o)
			ADD, ADDC, SUB, SUBC, NOT, AND, OR, XOR: begin
				n = r[13];
				z = (r == '0);
			end
			default: ;
		endcase
		return {c, n, v, z, r};
	endfunction

	// f is {c, n, v, z}
	function automatic logic jumpWanted(input logic [3:0] cd, input logic [3:0] f);
		case (cd)
			4'h0: return 1'b1;
			4'h1: return f[0];
			4'h2: return f[1];
			4'h4: return f[2];
			4'h8: return f[3];
			4'h7: return !f[3];
			4'hB: return !f[2];
			4'hD: return !f[1];
			4'hE: return !f[0];
			default: return 1'b0;
		endcase
	endfunction

	task automatic checkTest();
		logic [17:0] m;
		wordT        expAddr;
		wordT        expData;
		logic        ok;
		ok = !haltErr;
		runCount++;
		m = model(op, a, b, carry);
		expData = m[13:0];
		if (kind == kindAlu || kind == kindLoad) begin
			expAddr = 14'h80;
		end else if (kind == kindJump) begin
			expAddr = jumpWanted(cond, m[17:14]) ? 14'h82 : 14'h81;
		end else begin
			expAddr = 14'h70 + a;
		end
		if (kind == kindLoad || kind > kindLoad) begin
			expData = b;  // loaded word goes straight back out
		end
		if (kind == kindIdle) begin
			if (storeCount != 0) begin
				$display("test %0d: store seen although the core never ran", testNum);
				ok = 1'b0;
			end
		end else if (storeCount == 0) begin
			$display("test %0d %s: no store was seen", testNum, op.name());
			ok = 1'b0;
		end else if (storeCount > 1) begin
			$display("test %0d %s: %0d stores seen, one expected", testNum, op.name(),
				storeCount);
			ok = 1'b0;
		end else begin
			if (gotAddr != expAddr) begin
				$display("Fail dmAddr test %0d %s: got 0x%h expected 0x%h", testNum,
					op.name(), gotAddr, expAddr);
				ok = 1'b0;
			end
			if (gotData != expData) begin
				$display("Fail dmWrData test %0d %s: got 0x%h expected 0x%h", testNum,
					op.name(), gotData, expData);
				ok = 1'b0;
			end
		end
		if (ok) begin
			passCount++;
			$display("test %0d %s: pass", testNum, op.name());
		end else begin
			failCount++;
			$display("test %0d %s: failed", testNum, op.name());
		end
	endtask

	// ------------------------------
	// sampling on the falling edge
	// ------------------------------

	always @(negedge Clock_pin) begin
		if (rstN && !run) begin
			if (dmWrite) begin
				$display("test %0d: data memory written while the core was halted", testNum);
				haltErr = 1'b1;
			end
			if (pcOut != '0) begin
				$display("Fail pcOut test %0d: got 0x%h expected 0x%h", testNum, pcOut, 14'h0);
				haltErr = 1'b1;
			end
		end
		if (rstN && dmWrite) begin
			if (storeCount == 0) begin
				gotAddr = dmAddr;  // first store counts
				gotData = dmWrData;
			end
			storeCount++;
		end
		if (testDone) begin
			checkTest();
			storeCount = 0;
			haltErr = 1'b0;
		end
		if (allDone && !summaryDone) begin
			$display("tests run %0d, passed %0d, failed %0d", runCount, passCount, failCount);
			summaryDone = 1'b1;
		end
	end

endmodule

//--- bench/tbTop.sv
`timescale 1ns/1ns
`include "risc621_defines.svh"

module tbTop import risc621Pkg::*; ();

	localparam logic [2:0] kindIdle = 3'd0;
	localparam logic [2:0] kindAlu = 3'd1;
	localparam logic [2:0] kindJump = 3'd2;
	localparam logic [2:0] kindLoad = 3'd3;
	localparam logic [2:0] kindStore = 3'd4;
	localparam int rowCycles = 120;  // worst row is about 95

	typedef struct packed {
		logic [2:0] kind;
		opcodeE     op;
		wordT       a;
		wordT       b;      // operand b or shift amount
		logic       carry;  // carry left by the preset ADD
		logic [3:0] cond;
	} rowT;

	logic Clock_pin;
	logic rstN;
	logic run;
	logic loadEn;
	logic loadSel;
	wordT loadAddr;
	wordT loadData;
	logic dmWrite;
	wordT dmAddr;
	wordT dmWrData;
	wordT pcOut;
	rowT  rows [$];
	rowT  cur;
	int   testNum;
	logic testDone;
	logic allDone;
	int   failCount;
	wordT prog [32];
	int   seed = 32'he05d;
	int   cycleCount = 0;
	int   cycleLimit = 0;

	risc621Top DUT (.Clock_pin, .rstN, .run, .loadEn, .loadSel, .loadAddr, .loadData,
		.dmWrite, .dmAddr, .dmWrData, .pcOut);

	tbChecker scoreboard (.Clock_pin, .rstN, .run, .dmWrite, .dmAddr, .dmWrData, .pcOut,
		.testNum, .kind(cur.kind), .op(cur.op), .a(cur.a), .b(cur.b), .carry(cur.carry),
		.cond(cur.cond), .testDone, .allDone, .failCount);

	initial begin
		Clock_pin = 1'b0;
		forever #20 Clock_pin = ~Clock_pin;
	end

	initial begin
		while (cycleLimit == 0 || cycleCount <= cycleLimit) begin
			@(posedge Clock_pin);
			cycleCount++;
		end
		$display("run stopped after %0d cycles, the cycle limit was reached", cycleCount);
		$display("Test failures found");
		$finish;
	end

	// ------------------------------
	// test table
	// ------------------------------

	function automatic void addRow(input logic [2:0] k, input opcodeE o, input wordT x,
		input wordT y, input logic c, input logic [3:0] cd);
		rows.push_back('{kind: k, op: o, a: x, b: y, carry: c, cond: cd});
	endfunction

	function automatic void buildTable();
		opcodeE shiftOps [8] = '{SHLL, SHLA, SHRL, SHRA, ROTL, ROTR, RTLC, RTRC};
		opcodeE randOps [12] = '{ADD, SUB, ADDC, SUBC, AND, OR, XOR, NOT, RTLC, RTRC, SHRA,
			ROTL};
		condE   conds [9] = '{JU, JZ1, JV1, JN1, JC1, JC0, JN0, JV0, JZ0};
		addRow(kindIdle, NOP, 0, 0, 0, 0);
		addRow(kindAlu, ADD, 14'h1234, 14'h0DCC, 0, 0);
		addRow(kindAlu, ADD, 14'h3FFF, 14'h0001, 1, 0);
		addRow(kindAlu, SUB, 14'h0005, 14'h0009, 0, 0);
		addRow(kindAlu, SUB, 14'h2000, 14'h0001, 0, 0);
		addRow(kindAlu, ADDC, 14'h3FF5, 14'h000B, 0, 0);
		addRow(kindAlu, SUBC, 14'h0003, 14'h0007, 1, 0);
		addRow(kindAlu, CPY, 14'h0000, 14'h2A5A, 0, 0);
		addRow(kindAlu, NOT, 14'h0F0F, 14'h0000, 0, 0);
		addRow(kindAlu, AND, 14'h3C3C, 14'h0FF0, 0, 0);
		addRow(kindAlu, OR, 14'h2C01, 14'h0310, 0, 0);
		addRow(kindAlu, XOR, 14'h2AAA, 14'h2AAA, 0, 0);
		foreach (shiftOps[i]) begin
			for (int amt = 0; amt < 16; amt++) begin
				addRow(kindAlu, shiftOps[i], 14'h2D5B ^ wordT'(amt * 'h111), wordT'(amt),
					amt[0], 0);
			end
		end
		foreach (conds[i]) begin
			addRow(kindJump, ADD, 14'h1FFF, 14'h0001, 0, conds[i]);  // n and v set
			addRow(kindJump, SUB, 14'h0005, 14'h0005, 0, conds[i]);  // z and c set
		end
		addRow(kindJump, AND, 14'h2AAA, 14'h1555, 1, JZ1);
		addRow(kindJump, XOR, 14'h2000, 14'h0001, 0, JN1);
		addRow(kindJump, NOT, 14'h3FFF, 14'h0000, 0, JZ0);
		addRow(kindJump, OR, 14'h0100, 14'h0010, 1, JN0);
		addRow(kindLoad, LD, 14'h0002, 14'h3A5C, 0, 0);
		addRow(kindLoad, LD, 14'h0007, 14'h0421, 0, 0);
		addRow(kindLoad, LD, 14'h000F, 14'h1B7E, 0, 0);
		addRow(kindStore, ST, 14'h0000, 14'h2468, 0, 0);
		addRow(kindStore, ST, 14'h0005, 14'h1357, 0, 0);
		addRow(kindStore, ST, 14'h000F, 14'h3FFE, 0, 0);
		for (int i = 0; i < 24; i++) begin
			addRow(i[0] ? kindJump : kindAlu, randOps[$unsigned($random(seed)) % 12],
				wordT'($random(seed)), wordT'($random(seed)), $random(seed) & 1,
				conds[$unsigned($random(seed)) % 9]);
		end
	endfunction

	// ------------------------------
	// program builder and loader
	// ------------------------------

	function automatic wordT enc(input opcodeE o, input logic [3:0] hi, input logic [3:0] lo);
		return wordT'({o, hi, lo});
	endfunction

	function automatic wordT fillWord(input int addr);
		return wordT'((addr * 'h2B1) ^ 'h1C3);
	endfunction

	function automatic void buildProgram(input rowT r);
		logic [3:0] low;
		foreach (prog[i]) prog[i] = enc(NOP, 0, 0);
		low = (r.op inside {ADD, SUB, AND, OR, XOR, CPY}) ? 4'd5 : r.b[3:0];
		if (r.kind == kindLoad) begin
			prog[0] = enc(LD, 0, 8);  // R8 = index
			prog[1] = 14'h10;
			prog[5] = enc(LD, 8, 4);
			prog[6] = 14'h20;
			prog[10] = enc(ST, 1, 4);  // indexed by own address word
			prog[11] = 14'h80 - 14'd11;
			prog[12] = enc(JMP, 0, 0);
			prog[13] = 14'd12;
		end else if (r.kind == kindStore) begin
			prog[0] = enc(LD, 0, 4);
			prog[1] = 14'h11;
			prog[2] = enc(LD, 0, 9);
			prog[3] = 14'h10;
			prog[7] = enc(ST, 9, 4);
			prog[8] = 14'h70;
			prog[9] = enc(JMP, 0, 0);
			prog[10] = 14'd9;
		end else if (r.kind != kindIdle) begin
			prog[0] = enc(LD, 0, 4);
			prog[1] = 14'h10;
			prog[2] = enc(LD, 0, 5);
			prog[3] = 14'h11;
			prog[4] = enc(LD, 0, 6);
			prog[5] = 14'h12;
			prog[6] = enc(LD, 0, 7);
			prog[7] = 14'h13;
			prog[11] = enc(ADD, 6, 7);  // carry preset
			prog[14] = enc(r.op, 4, low);
			if (r.kind == kindAlu) begin
				prog[17] = enc(ST, 0, 4);
				prog[18] = 14'h80;
				prog[19] = enc(JMP, 0, 0);
				prog[20] = 14'd19;
			end else begin
				prog[16] = enc(JMP, 0, r.cond);
				prog[17] = 14'd22;
				prog[18] = enc(ST, 0, 4);  // not taken path
				prog[19] = 14'h81;
				prog[20] = enc(JMP, 0, 0);
				prog[21] = 14'd20;
				prog[22] = enc(ST, 0, 4);  // taken path
				prog[23] = 14'h82;
				prog[24] = enc(JMP, 0, 0);
				prog[25] = 14'd24;
			end
		end
	endfunction

	task automatic writeMem(input logic sel, input int addr, input wordT data);
		@(posedge Clock_pin);
		loadEn <= 1'b1;
		loadSel <= sel;
		loadAddr <= wordT'(addr);
		loadData <= data;
	endtask

	task automatic runRow(input int n, input rowT r);
		int waited;
		@(posedge Clock_pin);
		rstN <= 1'b0;
		run <= 1'b0;
		loadEn <= 1'b0;
		cur <= r;
		testNum <= n;
		repeat (4) @(posedge Clock_pin);
		rstN <= 1'b1;
		buildProgram(r);
		writeMem(1'b1, 'h10, r.a);
		writeMem(1'b1, 'h11, r.b);
		writeMem(1'b1, 'h12, r.carry ? 14'h3FFF : 14'h0000);
		writeMem(1'b1, 'h13, 14'h0001);
		if (r.kind == kindLoad) begin
			for (int i = 'h20; i < 'h30; i++) begin
				writeMem(1'b1, i, (i == 'h20 + int'(r.a)) ? r.b : fillWord(i));
			end
		end
		for (int i = 0; i < 32; i++) begin
			writeMem(1'b0, i, prog[i]);
		end
		@(posedge Clock_pin);
		loadEn <= 1'b0;
		if (r.kind == kindIdle) begin
			repeat (10) @(posedge Clock_pin);
		end else begin
			run <= 1'b1;
			for (waited = 0; waited < 60; waited++) begin
				@(negedge Clock_pin);
				if (dmWrite) break;
			end
			repeat (12) @(posedge Clock_pin);  // any late store shows here
		end
		@(posedge Clock_pin);
		testDone <= 1'b1;
		@(posedge Clock_pin);
		testDone <= 1'b0;
	endtask

	// ------------------------------
	// main sequence
	// ------------------------------

	initial begin
		rstN = 1'b0;
		run = 1'b0;
		loadEn = 1'b0;
		loadSel = 1'b0;
		loadAddr = '0;
		loadData = '0;
		testDone = 1'b0;
		allDone = 1'b0;
		testNum = 0;
		cur = '0;
		buildTable();
		cycleLimit = rows.size() * rowCycles + 50;
		repeat (4) @(posedge Clock_pin);
		rstN <= 1'b1;
		for (int i = 0; i < rows.size(); i++) begin
			runRow(i, rows[i]);
		end
		@(posedge Clock_pin);
		allDone <= 1'b1;
		@(posedge Clock_pin);
		if (failCount == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

//--- hw/aluCore.sv
`timescale 1ns/1ns
`include "risc621_defines.svh"

module aluCore import risc621Pkg::*; (
	input  decodedT  decoded,
	input  logic     carryIn,
	output executedT executed
);

	wordT             a;
	wordT             b;
	wordT             res;
	logic [3:0]       amt;
	logic [3:0]       rotAmt;
	logic [`WORD_W:0] sum;
	logic [`WORD_W:0] rcIn;
	logic [`WORD_W:0] rcOut;
	flagsT            fl;
	logic             fv;

	assign a = decoded.opA;
	assign b = decoded.opB;
	assign amt = decoded.amtCond;
	assign rotAmt = (amt >= 4'd14) ? amt - 4'd14 : amt;  // 14 and 15 wrap
	assign rcIn = {a, carryIn};  // 15-bit ring for rotate through carry

	// ------------------------------
	// result and flags
	// ------------------------------

	always_comb begin
		res = '0;
		sum = '0;
		rcOut = rcIn;
		fl = '{c: carryIn, n: 1'b0, v: 1'b0, z: 1'b0};
		fv = 1'b0;

		case (decoded.op)
			ADD, ADDC: begin
				sum = {1'b0, a} + {1'b0, b};
				res = sum[`WORD_W-1:0];
				fl.c = sum[`WORD_W];
				fl.v = (a[`WORD_W-1] == b[`WORD_W-1]) && (res[`WORD_W-1] != a[`WORD_W-1]);
				fv = 1'b1;
			end
			SUB, SUBC: begin
				sum = {1'b0, a} + {1'b0, ~b} + 1'b1;  // carry set means no borrow
				res = sum[`WORD_W-1:0];
				fl.c = sum[`WORD_W];
				fl.v = (a[`WORD_W-1] != b[`WORD_W-1]) && (res[`WORD_W-1] != a[`WORD_W-1]);
				fv = 1'b1;
			end
			NOT: begin
				res = ~a;
				fv = 1'b1;
			end
			AND: begin
				res = a & b;
				fv = 1'b1;
			end
			OR: begin
				res = a | b;
				fv = 1'b1;
			end
			XOR: begin
				res = a ^ b;
				fv = 1'b1;
			end
			CPY: res = b;
			SHLL, SHLA: res = a << amt;  // 14 and up clear the word
			SHRL: res = a >> amt;
			SHRA: res = wordT'($signed(a) >>> amt);  // 13 and up fill with sign
			ROTL: res = (a << rotAmt) | (a >> (4'd14 - rotAmt));
			ROTR: res = (a >> rotAmt) | (a << (4'd14 - rotAmt));
			RTLC: begin
				rcOut = (rcIn << amt) | (rcIn >> (4'd15 - amt));
				res = rcOut[`WORD_W:1];
				fl.c = rcOut[0];
				fv = 1'b1;
			end
			RTRC: begin
				rcOut = (rcIn >> amt) | (rcIn << (4'd15 - amt));
				res = rcOut[`WORD_W:1];
				fl.c = rcOut[0];
				fv = 1'b1;
			end
			default: res = '0;
		endcase

		fl.n = res[`WORD_W-1];
		fl.z = (res == '0);
	end

	always_comb begin
		executed.op = decoded.op;
		executed.dst = decoded.dst;
		executed.src = decoded.src;
		executed.result = decoded.wrDst ? res : '0;  // quiet when nothing writes back
		executed.effAddr = decoded.addrBase + decoded.addrIndex;
		executed.flags = fl;
		executed.flagsValid = fv;
		executed.cond = condE'(decoded.amtCond);
	end

endmodule

//--- hw/fetchStage.sv
`timescale 1ns/1ns

module fetchStage import risc621Pkg::*; (
	input  logic    Clock_pin,
	input  logic    rstN,
	input  logic    run,
	input  wordT    pmData,
	input  logic    addrWordNext,
	input  logic    jumpTaken,
	input  wordT    jumpTarget,
	output wordT    pmAddr,
	output fetchedT fetched
);

	wordT pc;

	// ------------------------------
	// program counter
	// ------------------------------

	always_ff @(posedge Clock_pin or negedge rstN) begin
		if (!rstN) begin
			pc <= '0;
		end else if (!run) begin
			pc <= '0;  // held while loading
		end else if (jumpTaken) begin
			pc <= jumpTarget;
		end else begin
			pc <= pc + 1'b1;
		end
	end

	assign pmAddr = pc;

	// address word goes to operand stage directly, bubble here
	always_comb begin
		fetched.pc = pc;
		fetched.instr = (run && !addrWordNext) ? pmData : '0;
	end

endmodule

//--- hw/operandStage.sv
`timescale 1ns/1ns
`include "risc621_defines.svh"

module operandStage import risc621Pkg::*; (
	input  fetchedT fetched,
	input  wordT    pmData,
	input  wordT    dataA,
	input  wordT    dataB,
	output regIdxT  rdA,
	output regIdxT  rdB,
	output logic    addrWordNext,
	output decodedT decoded
);

	wordT   ir;
	opcodeE opcode;
	regIdxT idxField;

	assign ir = fetched.instr;
	assign opcode = opcodeE'(ir[`WORD_W-1:8]);
	assign idxField = ir[7:4];

	// fields are read unconditionally, decode picks what it needs
	assign rdA = ir[7:4];
	assign rdB = ir[3:0];

	always_comb begin
		decoded = '0;
		decoded.op = opcode;
		decoded.dst = ir[7:4];
		decoded.src = ir[3:0];
		decoded.amtCond = ir[3:0];
		addrWordNext = 1'b0;

		case (opcode)
			LD, ST, JMP: begin
				addrWordNext = 1'b1;  // pmData is the address word
				decoded.addrBase = pmData;
				if (idxField == 4'd0) begin
					decoded.addrIndex = '0;
				end else if (idxField == 4'd1) begin
					decoded.addrIndex = fetched.pc + 1'b1;  // where the address word sits
				end else begin
					decoded.addrIndex = dataA;
				end
				decoded.dst = ir[3:0];  // LD target
				decoded.wrDst = (opcode == LD);
			end
			CPY: begin
				decoded.opB = dataB;
				decoded.wrDst = 1'b1;
			end
			ADD, SUB, AND, OR, XOR: begin
				decoded.opA = dataA;
				decoded.opB = dataB;
				decoded.wrDst = 1'b1;
			end
			ADDC, SUBC: begin
				decoded.opA = dataA;
				decoded.opB = {{(`WORD_W-4){1'b0}}, ir[3:0]};  // zero-extended constant
				decoded.wrDst = 1'b1;
			end
			NOT, SHLL, SHRL, SHLA, SHRA, ROTL, ROTR, RTLC, RTRC: begin
				decoded.opA = dataA;
				decoded.wrDst = 1'b1;
			end
			default: begin
				decoded.op = NOP;  // unknown opcodes do nothing
			end
		endcase
	end

endmodule

//--- hw/pipeReg.sv
`timescale 1ns/1ns

module pipeReg import risc621Pkg::*; #(
	parameter type payloadT = fetchedT
) (
	input  logic    Clock_pin,
	input  logic    rstN,
	input  logic    flush,
	input  payloadT d,
	output payloadT q
);

	// all-zero payload decodes as NOP in every stage
	always_ff @(posedge Clock_pin or negedge rstN) begin
		if (!rstN) begin
			q <= payloadT'('0);
		end else if (flush) begin
			q <= payloadT'('0);  // squash younger instruction
		end else begin
			q <= d;
		end
	end

endmodule

//--- hw/regFile.sv
`timescale 1ns/1ns
`include "risc621_defines.svh"

module regFile import risc621Pkg::*; (
	input  logic   Clock_pin,
	input  logic   rstN,
	input  regIdxT rdA,
	input  regIdxT rdB,
	input  regIdxT rdC,
	output wordT   dataA,
	output wordT   dataB,
	output wordT   dataC,
	input  logic   weA,
	input  regIdxT waA,
	input  wordT   wdA
);

	wordT regs [`REG_CNT];

	always_ff @(posedge Clock_pin or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < `REG_CNT; i++) begin
				regs[i] <= '0;
			end
		end else if (weA) begin
			regs[waA] <= wdA;
		end
	end

	assign dataA = regs[rdA];  // operand a or index
	assign dataB = regs[rdB];  // operand b
	assign dataC = regs[rdC];  // store data at retire

endmodule

//--- hw/retireStage.sv
`timescale 1ns/1ns
`include "risc621_defines.svh"

module retireStage import risc621Pkg::*; (
	input  logic     Clock_pin,
	input  logic     rstN,
	input  executedT executed,
	input  wordT     dmRdData,
	output logic     regWe,
	output regIdxT   regWa,
	output wordT     regWd,
	output logic     dmWrite,
	output wordT     dmAddr,
	output wordT     dmWrData,
	input  wordT     storeData,
	output regIdxT   rdStore,
	output logic     carryOut,
	output logic     jumpTaken,
	output wordT     jumpTarget
);

	logic [`SR_W-1:0] sr;
	logic [3:0]       flagBits;
	logic [3:0]       condBits;
	logic             condHit;

	// ------------------------------
	// write-back and memory
	// ------------------------------

	always_comb begin
		case (executed.op)
			LD, CPY, ADD, SUB, ADDC, SUBC, NOT, AND, OR, XOR,
			SHLL, SHRL, SHLA, SHRA, ROTL, ROTR, RTLC, RTRC: regWe = 1'b1;
			default: regWe = 1'b0;
		endcase
	end

	assign regWa = executed.dst;
	assign regWd = (executed.op == LD) ? dmRdData : executed.result;

	assign rdStore = executed.src;
	assign dmWrite = (executed.op == ST);  // one retire cycle only
	assign dmAddr = executed.effAddr;
	assign dmWrData = storeData;

	// ------------------------------
	// status register
	// ------------------------------

	always_ff @(posedge Clock_pin or negedge rstN) begin
		if (!rstN) begin
			sr <= '0;
		end else if (executed.flagsValid) begin
			case (executed.op)
				ADD, SUB, ADDC, SUBC: begin
					sr[`FLAG_C] <= executed.flags.c;
					sr[`FLAG_N] <= executed.flags.n;
					sr[`FLAG_V] <= executed.flags.v;
					sr[`FLAG_Z] <= executed.flags.z;
				end
				NOT, AND, OR, XOR: begin
					sr[`FLAG_N] <= executed.flags.n;  // c and v kept
					sr[`FLAG_Z] <= executed.flags.z;
				end
				RTLC, RTRC: sr[`FLAG_C] <= executed.flags.c;
				default: sr <= sr;
			endcase
		end
	end

	assign carryOut = sr[`FLAG_C];

	// ------------------------------
	// jump decision
	// ------------------------------

	assign flagBits = {sr[`FLAG_C], sr[`FLAG_N], sr[`FLAG_V], sr[`FLAG_Z]};
	assign condBits = executed.cond;

	always_comb begin
		case (executed.cond)
			JU, JC1, JN1, JV1, JZ1: condHit = ((flagBits & condBits) == condBits);
			JC0, JN0, JV0, JZ0: condHit = ((flagBits | condBits) == condBits);
			default: condHit = 1'b0;  // undefined codes never jump
		endcase
	end

	assign jumpTaken = (executed.op == JMP) && condHit;
	assign jumpTarget = executed.effAddr;

endmodule

//--- hw/risc621Pkg.sv
`include "risc621_defines.svh"

package risc621Pkg;

	typedef logic [`WORD_W-1:0] wordT;
	typedef logic [`REG_IDX_W-1:0] regIdxT;

	typedef enum logic [5:0] {
		NOP  = 6'h00,
		LD   = 6'h01,
		ST   = 6'h02,
		CPY  = 6'h03,
		JMP  = 6'h10,
		ADD  = 6'h20,
		SUB  = 6'h21,
		ADDC = 6'h22,  // immediate operand in low nibble
		SUBC = 6'h23,
		NOT  = 6'h28,
		AND  = 6'h29,
		OR   = 6'h2A,
		XOR  = 6'h2B,
		SHLL = 6'h2C,
		SHRL = 6'h2D,
		SHLA = 6'h2E,
		SHRA = 6'h2F,
		ROTL = 6'h30,
		ROTR = 6'h31,
		RTLC = 6'h32,  // rotate through carry
		RTRC = 6'h33
	} opcodeE;

	// jump codes line up with the c n v z flag bits
	typedef enum logic [3:0] {
		JU  = 4'h0,
		JZ1 = 4'h1,
		JV1 = 4'h2,
		JN1 = 4'h4,
		JC0 = 4'h7,
		JC1 = 4'h8,
		JN0 = 4'hB,
		JV0 = 4'hD,
		JZ0 = 4'hE
	} condE;

	typedef struct packed {
		logic c;
		logic n;
		logic v;
		logic z;
	} flagsT;

	typedef struct packed {
		wordT instr;
		wordT pc;  // address of instr
	} fetchedT;

	typedef struct packed {
		opcodeE     op;
		regIdxT     dst;
		regIdxT     src;
		wordT       opA;
		wordT       opB;
		wordT       addrBase;   // second instruction word
		wordT       addrIndex;
		logic [3:0] amtCond;    // shift amount or jump code
		logic       wrDst;
	} decodedT;

	typedef struct packed {
		opcodeE op;
		regIdxT dst;
		regIdxT src;
		wordT   result;
		wordT   effAddr;
		flagsT  flags;
		logic   flagsValid;
		condE   cond;
	} executedT;

endpackage

//--- hw/risc621Top.sv
`timescale 1ns/1ns
`include "risc621_defines.svh"

module risc621Top import risc621Pkg::*; (
	input  logic Clock_pin,
	input  logic rstN,
	input  logic run,
	input  logic loadEn,
	input  logic loadSel,   // 0 program, 1 data
	input  wordT loadAddr,
	input  wordT loadData,
	output logic dmWrite,
	output wordT dmAddr,
	output wordT dmWrData,
	output wordT pcOut
);

	wordT     pmAddr, pmData, dmRdData;
	wordT     dmWAddr, dmWData;
	logic     pmWe, dmWe, pipeFlush;
	logic     addrWordNext, jumpTaken, carry, regWe;
	wordT     jumpTarget, dataA, dataB, storeData, regWd;
	regIdxT   rdA, rdB, rdStore, regWa;
	fetchedT  fetchedD, fetchedQ;
	decodedT  decodedD, decodedQ;
	executedT executedD, executedQ;

	// loader only while halted, stores win the shared port
	assign pmWe = loadEn & ~loadSel & ~run;
	assign dmWe = dmWrite | (loadEn & loadSel & ~run);
	assign dmWAddr = dmWrite ? dmAddr : loadAddr;
	assign dmWData = dmWrite ? dmWrData : loadData;
	assign pipeFlush = jumpTaken | ~run;
	assign pcOut = pmAddr;

	wordRam #(.depth(`PM_DEPTH)) progMem (.Clock_pin, .we(pmWe), .wAddr(loadAddr),
		.wData(loadData), .rAddr(pmAddr), .rData(pmData));
	wordRam #(.depth(`DM_DEPTH)) dataMem (.Clock_pin, .we(dmWe), .wAddr(dmWAddr),
		.wData(dmWData), .rAddr(dmAddr), .rData(dmRdData));

	fetchStage fetch (.Clock_pin, .rstN, .run, .pmData, .addrWordNext, .jumpTaken,
		.jumpTarget, .pmAddr, .fetched(fetchedD));
	pipeReg #(.payloadT(fetchedT)) fetchReg (.Clock_pin, .rstN, .flush(pipeFlush),
		.d(fetchedD), .q(fetchedQ));

	operandStage operand (.fetched(fetchedQ), .pmData, .dataA, .dataB, .rdA, .rdB,
		.addrWordNext, .decoded(decodedD));
	regFile regs (.Clock_pin, .rstN, .rdA, .rdB, .rdC(rdStore), .dataA, .dataB,
		.dataC(storeData), .weA(regWe), .waA(regWa), .wdA(regWd));
	pipeReg #(.payloadT(decodedT)) decodeReg (.Clock_pin, .rstN, .flush(pipeFlush),
		.d(decodedD), .q(decodedQ));

	aluCore alu (.decoded(decodedQ), .carryIn(carry), .executed(executedD));
	pipeReg #(.payloadT(executedT)) executeReg (.Clock_pin, .rstN, .flush(pipeFlush),
		.d(executedD), .q(executedQ));

	retireStage retire (.Clock_pin, .rstN, .executed(executedQ), .dmRdData, .regWe, .regWa,
		.regWd, .dmWrite, .dmAddr, .dmWrData, .storeData, .rdStore, .carryOut(carry),
		.jumpTaken, .jumpTarget);

endmodule

//--- hw/risc621_defines.svh
`ifndef RISC621_DEFINES_SVH
`define RISC621_DEFINES_SVH

// ------------------------------
// datapath sizes
// ------------------------------

`define WORD_W     14  // data and instruction width
`define REG_CNT    16  // working registers
`define REG_IDX_W  4   // register index width

// ------------------------------
// memories
// ------------------------------

`define PM_DEPTH   256  // program memory words
`define DM_DEPTH   256  // data memory words

// ------------------------------
// status register
// ------------------------------

`define SR_W       12
`define FLAG_C     11  // carry
`define FLAG_N     10  // negative
`define FLAG_V     9   // overflow
`define FLAG_Z     8   // zero

`endif

//--- hw/wordRam.sv
`timescale 1ns/1ns
`include "risc621_defines.svh"

module wordRam #(
	parameter int depth = 256
) (
	input  logic              Clock_pin,
	input  logic              we,
	input  logic [`WORD_W-1:0] wAddr,
	input  logic [`WORD_W-1:0] wData,
	input  logic [`WORD_W-1:0] rAddr,
	output logic [`WORD_W-1:0] rData
);

	localparam int addrW = $clog2(depth);

	logic [`WORD_W-1:0] mem [depth];

	always_ff @(posedge Clock_pin) begin
		if (we) begin
			mem[wAddr[addrW-1:0]] <= wData;
		end
	end

	// upper address bits ignored, memory wraps
	assign rData = mem[rAddr[addrW-1:0]];

endmodule

//--- run.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f sim.f --top-module tbTop -o tbSim
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

out=$(./obj_dir/tbSim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q 'All tests passed!'; then
	exit 0
fi
exit 1

//--- sim.f
+incdir+hw
hw/risc621Pkg.sv
hw/wordRam.sv
hw/pipeReg.sv
hw/fetchStage.sv
hw/regFile.sv
hw/operandStage.sv
hw/aluCore.sv
hw/retireStage.sv
hw/risc621Top.sv
bench/tbChecker.sv
bench/tbTop.sv
